// File: Bender.yml
package:
  name: datapath

sources:
  - include_dirs:
      - source
    files:
      - source/datapathPkg.sv
      - source/regSlice.sv
      - source/aluCore.sv
      - source/microIssue.sv
      - source/writeBack.sv
      - source/datapathTop.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/datapathAssert.sv
      - dv/datapathTb.sv

// File: dv/datapathAssert.sv
// ----------------------------------------------------------
// port properties of the datapath top level
// ----------------------------------------------------------
`timescale 1ns/1ps

module datapathAssert (
  input logic       phi2,
  input logic       rstN,
  input logic       dataOutValid,
  input logic [3:0] flagsNvzc
);

  // no readout strobe while held in reset
  noPulseInReset: assert property (@(posedge phi2) !rstN |-> !dataOutValid)
    else $error("dataOutValid high during reset");

  flagsKnown: assert property (@(posedge phi2) disable iff (!rstN) !$isunknown(flagsNvzc))
    else $error("flagsNvzc unknown after reset");

  // strobe lasts one cycle
  singleCyclePulse: assert property (
    @(posedge phi2) disable iff (!rstN) dataOutValid |=> !dataOutValid)
    else $error("dataOutValid high for two cycles in a row");

endmodule

bind datapathTop datapathAssert portChecks (
  .phi2        (phi2),
  .rstN        (rstN),
  .dataOutValid(dataOutValid),
  .flagsNvzc   (flagsNvzc)
);

// File: dv/datapathTb.sv
// ----------------------------------------------------------
// datapath testbench, seeded random micro words checked
// against an in-order reference model
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "datapathDefines.svh"

module datapathTb;
  import datapathPkg::*;

  localparam int NUM_WORDS = 400;
  localparam int NUM_DIRECTED = 9;
  localparam int TIMEOUT_CYCLES = 16 + NUM_WORDS + 50;

  logic                   phi2;
  logic                   rstN;
  logic                   microValid;
  microWord_t             microWord;
  logic [`DATA_WIDTH-1:0] dataIn;
  logic [`DATA_WIDTH-1:0] dataOut;
  logic                   dataOutValid;
  logic [3:0]             flagsNvzc;

  integer seed = 32'h3d596806;
  int     cycleCount = 0;
  int     checkCount = 0;
  int     errorCount = 0;

  // reference state with flags packed as {N, V, Z, C}
  logic [7:0] modelReg [`NUM_REGS];
  logic       mN = 1'b0;
  logic       mV = 1'b0;
  logic       mZ = 1'b0;
  logic       mC = 1'b0;
  logic [3:0] flagHist [3] = '{4'h0, 4'h0, 4'h0};
  logic [7:0] expOut [$];
  int         expCycle [$];

  datapathTop UUT (
    .phi2        (phi2),
    .rstN        (rstN),
    .microValid  (microValid),
    .microWord   (microWord),
    .dataIn      (dataIn),
    .dataOut     (dataOut),
    .dataOutValid(dataOutValid),
    .flagsNvzc   (flagsNvzc)
  );

  initial begin
    phi2 = 1'b0;
    forever #20 phi2 = ~phi2;
  end

  task automatic checkValue(input string name, input logic [15:0] actual,
                            input logic [15:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("ERROR %0t %s actual %h expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic updateNz(input logic [7:0] v);
    mN = v[7];
    mZ = (v == 8'h00);
  endtask

  // apply one accepted word in program order
  task automatic applyWord(input microWord_t w, input logic [7:0] din);
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] r;
    logic [8:0] wide;
    logic       cin;
    if (!w.raw[15]) begin
      if (w.xfer.stepEn) begin
        if (w.xfer.dst < `NUM_REGS) begin
          modelReg[w.xfer.dst] = w.xfer.src[0] ? modelReg[w.xfer.dst] - 8'd1
                                               : modelReg[w.xfer.dst] + 8'd1;
          updateNz(modelReg[w.xfer.dst]);
        end
      end else begin
        if (w.xfer.src < `NUM_REGS) a = modelReg[w.xfer.src];
        else if (w.xfer.src == `SRC_DATA_IN) a = din;
        else a = w.xfer.imm;
        if (w.xfer.dst < `NUM_REGS) begin
          modelReg[w.xfer.dst] = a;
          updateNz(a);
        end else if (w.xfer.dst == `DST_DOR) begin
          expOut.push_back(a);
          expCycle.push_back(cycleCount + 3);
        end
      end
    end else begin
      a = modelReg[w.alu.regA];
      b = w.alu.bFromDataIn ? din : modelReg[w.alu.regB];
      cin = w.alu.useCarry & mC;
      case (w.raw[14:12])
        3'd0: begin
          wide = a + b + cin;
          r = wide[7:0];
          mC = wide[8];
          mV = (a[7] ~^ b[7]) & (a[7] ^ r[7]);
        end
        3'd1: r = a & b;
        3'd2: r = a ^ b;
        3'd4: begin
          r = {cin, a[7:1]};
          mC = a[0];
        end
        default: r = a | b;
      endcase
      modelReg[w.alu.dst] = r;
      updateNz(r);
    end
  endtask

  function automatic microWord_t directedWord(input int idx);
    microWord_t w;
    case (idx)
      0: w.raw = {1'b0, `SRC_IMM, 3'd0, 1'b0, 8'hFF};
      // step A up right behind the load so it wraps to zero
      1: w.raw = {1'b0, 3'd0, 3'd0, 1'b1, 8'h00};
      2: w.raw = {1'b0, 3'd0, `DST_DOR, 1'b0, 8'h00};
      3: w.raw = {1'b0, 3'd1, 3'd0, 1'b1, 8'h00};
      4: w.raw = {1'b0, 3'd0, `DST_DOR, 1'b0, 8'h00};
      5: w.raw = {1'b0, `SRC_DATA_IN, 3'd1, 1'b0, 8'h00};
      6: w.raw = {1'b0, 3'd1, `DST_DOR, 1'b0, 8'h00};
      // Y = A + X gives signed overflow and carry out
      7: w.raw = {1'b1, 3'd0, 2'd0, 2'd1, 2'd2, 1'b0, 1'b0, 4'h0};
      default: w.raw = {1'b0, 3'd2, `DST_DOR, 1'b0, 8'h00};
    endcase
    return w;
  endfunction

  // roughly one transfer in three
  task automatic makeRandomWord(output microWord_t w);
    w.raw = $random(seed);
    if ({$random(seed)} % 3 == 0) begin
      w.xfer.kind = 1'b0;
      w.xfer.dst = {$random(seed)} % 6;
      if (w.xfer.dst == 3'd5) w.xfer.dst = `DST_DOR;
      if (!w.xfer.stepEn) w.xfer.src = {$random(seed)} % 6;
    end else begin
      w.alu.kind = 1'b1;
    end
  endtask

  function automatic logic isReadout(input microWord_t w);
    return !w.raw[15] && !w.xfer.stepEn && (w.xfer.dst == `DST_DOR);
  endfunction

  always @(posedge phi2) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("timeout, run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  // outputs are stable at the falling edge
  always @(negedge phi2) begin
    logic expectPulse;
    expectPulse = (expCycle.size() > 0) && (expCycle[0] == cycleCount);
    checkValue("dataOutValid", dataOutValid, expectPulse);
    if (expectPulse) begin
      checkValue("dataOut", dataOut, expOut.pop_front());
      void'(expCycle.pop_front());
    end
    checkValue("flagsNvzc", flagsNvzc, flagHist[2]);
    flagHist[2] = flagHist[1];
    flagHist[1] = flagHist[0];
    if (rstN && microValid) applyWord(microWord, dataIn);
    flagHist[0] = {mN, mV, mZ, mC};
  end

  initial begin
    microWord_t w;
    logic       v;
    logic [7:0] d;
    logic       prevReadout;
    rstN = 1'b0;
    microValid = 1'b0;
    microWord = '0;
    dataIn = '0;
    prevReadout = 1'b0;
    for (int r = 0; r < `NUM_REGS; r++) modelReg[r] = 8'h00;
    repeat (16) @(posedge phi2);
    rstN <= 1'b1;
    for (int i = 0; i < NUM_WORDS; i++) begin
      @(posedge phi2);
      if (i < NUM_DIRECTED) begin
        w = directedWord(i);
        v = 1'b1;
        d = 8'h80;
      end else begin
        makeRandomWord(w);
        v = ({$random(seed)} % 8) != 0;
        d = $random(seed);
      end
      // keep readout strobes apart
      if (prevReadout && isReadout(w)) w.xfer.dst = {1'b0, w.xfer.imm[1:0]};
      prevReadout = v && isReadout(w);
      microValid <= v;
      microWord <= w;
      dataIn <= d;
    end
    @(posedge phi2);
    microValid <= 1'b0;
    repeat (6) @(posedge phi2);
    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: source/aluCore.sv
// ----------------------------------------------------------
// combinational ALU, sum, logic ops and shift right
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "datapathDefines.svh"

module aluCore (
  input  logic [`DATA_WIDTH-1:0] opA,
  input  logic [`DATA_WIDTH-1:0] opB,
  input  datapathPkg::aluOp_t    op,
  input  logic                   carryIn,
  output logic [`DATA_WIDTH-1:0] result,
  output logic                   carryOut,
  output logic                   overflowOut
);
  import datapathPkg::*;

  // one extra bit to catch carry out of bit 7
  logic [`DATA_WIDTH:0] sum;

  always_comb begin
    sum = {1'b0, opA} + {1'b0, opB} + {{`DATA_WIDTH{1'b0}}, carryIn};
    result      = opA | opB;
    carryOut    = 1'b0;
    overflowOut = 1'b0;
    case (op)
      aluSum: begin
        result   = sum[`DATA_WIDTH-1:0];
        carryOut = sum[`DATA_WIDTH];
        // operands agree in sign, result does not
        overflowOut = (opA[`DATA_WIDTH-1] == opB[`DATA_WIDTH-1]) &&
                      (sum[`DATA_WIDTH-1] != opA[`DATA_WIDTH-1]);
      end
      aluAnd: result = opA & opB;
      aluEor: result = opA ^ opB;
      aluShiftRight: begin
        result   = {carryIn, opA[`DATA_WIDTH-1:1]};
        carryOut = opA[0];
      end
      default: result = opA | opB;
    endcase
  end

endmodule

// File: source/datapathDefines.svh
// ----------------------------------------------------------
// datapath widths, register count and transfer bus codes
// ----------------------------------------------------------
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// byte width of every bus and register
`define DATA_WIDTH 8

// architectural registers A=0, X=1, Y=2, S=3
`define NUM_REGS 4

// width of one micro word
`define MICRO_WIDTH 16

// transfer source codes above the register range
`define SRC_DATA_IN 3'd4
`define SRC_IMM 3'd5

// transfer destination for the data output register
`define DST_DOR 3'd4

`endif

// File: source/datapathPkg.sv
// ----------------------------------------------------------
// micro word layouts and ALU operation codes
// ----------------------------------------------------------
`include "datapathDefines.svh"

package datapathPkg;

  // codes 5 to 7 fall through to or
  typedef enum logic [2:0] {
    aluSum        = 3'd0,
    aluAnd        = 3'd1,
    aluEor        = 3'd2,
    aluOr         = 3'd3,
    aluShiftRight = 3'd4
  } aluOp_t;

  // kind = 0, byte moves and register steps
  typedef struct packed {
    logic                   kind;
    logic [2:0]             src;
    logic [2:0]             dst;
    logic                   stepEn;
    logic [`DATA_WIDTH-1:0] imm;
  } transferForm_t;

  // kind = 1, two-operand ALU with flag update
  typedef struct packed {
    logic       kind;
    aluOp_t     op;
    logic [1:0] regA;
    logic [1:0] regB;
    logic [1:0] dst;
    logic       useCarry;
    logic       bFromDataIn;
    logic [3:0] reserved;
  } aluForm_t;

  // top bit selects which view applies
  typedef union packed {
    transferForm_t          xfer;
    aluForm_t               alu;
    logic [`MICRO_WIDTH-1:0] raw;
  } microWord_t;

endpackage

// File: source/datapathTop.sv
// ----------------------------------------------------------
// two-stage micro-op datapath, A X Y S and NVZC flags
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "datapathDefines.svh"

module datapathTop (
  input  logic                   phi2,
  input  logic                   rstN,
  input  logic                   microValid,
  input  datapathPkg::microWord_t microWord,
  input  logic [`DATA_WIDTH-1:0] dataIn,
  output logic [`DATA_WIDTH-1:0] dataOut,
  output logic                   dataOutValid,
  output logic [3:0]             flagsNvzc
);
  import datapathPkg::*;

  logic                                  issueValid;
  microWord_t                            issueWord;
  logic [`DATA_WIDTH-1:0]                operandA;
  logic [`DATA_WIDTH-1:0]                operandB;
  logic [`NUM_REGS-1:0]                  loadEn;
  logic [`NUM_REGS-1:0]                  stepEn;
  logic                                  stepDown;
  logic [`DATA_WIDTH-1:0]                writeData;
  logic [`NUM_REGS-1:0][`DATA_WIDTH-1:0] regNext;

  microIssue issue (
    .phi2      (phi2),
    .rstN      (rstN),
    .microValid(microValid),
    .microWord (microWord),
    .dataIn    (dataIn),
    .regNext   (regNext),
    .issueValid(issueValid),
    .issueWord (issueWord),
    .operandA  (operandA),
    .operandB  (operandB)
  );

  // slice index 0..3 is A X Y S
  for (genvar i = 0; i < `NUM_REGS; i++) begin : genRegs
    regSlice slice (
      .phi2     (phi2),
      .rstN     (rstN),
      .loadEn   (loadEn[i]),
      .stepEn   (stepEn[i]),
      .stepDown (stepDown),
      .writeData(writeData),
      .value    (),
      .regNext  (regNext[i])
    );
  end

  writeBack wb (
    .phi2        (phi2),
    .rstN        (rstN),
    .issueValid  (issueValid),
    .issueWord   (issueWord),
    .operandA    (operandA),
    .operandB    (operandB),
    .loadEn      (loadEn),
    .stepEn      (stepEn),
    .stepDown    (stepDown),
    .writeData   (writeData),
    .dataOut     (dataOut),
    .dataOutValid(dataOutValid),
    .flagsNvzc   (flagsNvzc)
  );

endmodule

// File: source/microIssue.sv
// ----------------------------------------------------------
// issue stage, accepts micro words and captures operands
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "datapathDefines.svh"

module microIssue (
  input  logic                                 phi2,
  input  logic                                 rstN,
  input  logic                                 microValid,
  input  datapathPkg::microWord_t              microWord,
  input  logic [`DATA_WIDTH-1:0]               dataIn,
  input  logic [`NUM_REGS-1:0][`DATA_WIDTH-1:0] regNext,
  output logic                                 issueValid,
  output datapathPkg::microWord_t              issueWord,
  output logic [`DATA_WIDTH-1:0]               operandA,
  output logic [`DATA_WIDTH-1:0]               operandB
);
  import datapathPkg::*;

  logic                   acceptValid;
  microWord_t             acceptWord;
  logic [`DATA_WIDTH-1:0] acceptData;
  logic [`DATA_WIDTH-1:0] nextA;
  logic [`DATA_WIDTH-1:0] nextB;

  // word and data bus sampled together
  always_ff @(posedge phi2 or negedge rstN) begin
    if (!rstN) begin
      acceptValid <= 1'b0;
    end else begin
      acceptValid <= microValid;
    end
  end

  always_ff @(posedge phi2) begin
    if (microValid) begin
      acceptWord <= microWord;
      acceptData <= dataIn;
    end
  end

  // regNext already holds any write in progress, so no hazard compare
  always_comb begin
    nextA = '0;
    nextB = '0;
    if (acceptWord.xfer.kind == 1'b0) begin
      if (acceptWord.xfer.stepEn) begin
        nextA = regNext[acceptWord.xfer.dst[1:0]];
      end else if (acceptWord.xfer.src < `NUM_REGS) begin
        nextA = regNext[acceptWord.xfer.src[1:0]];
      end else if (acceptWord.xfer.src == `SRC_DATA_IN) begin
        nextA = acceptData;
      end else if (acceptWord.xfer.src == `SRC_IMM) begin
        nextA = acceptWord.xfer.imm;
      end
    end else begin
      nextA = regNext[acceptWord.alu.regA];
      nextB = acceptWord.alu.bFromDataIn ? acceptData : regNext[acceptWord.alu.regB];
    end
  end

  always_ff @(posedge phi2 or negedge rstN) begin
    if (!rstN) begin
      issueValid <= 1'b0;
    end else begin
      issueValid <= acceptValid;
    end
  end

  // operands held for the write-back stage
  always_ff @(posedge phi2) begin
    if (acceptValid) begin
      issueWord <= acceptWord;
      operandA  <= nextA;
      operandB  <= nextB;
    end
  end

endmodule

// File: source/regSlice.sv
// ----------------------------------------------------------
// one architectural register with load and step
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "datapathDefines.svh"

module regSlice (
  input  logic                   phi2,
  input  logic                   rstN,
  input  logic                   loadEn,
  input  logic                   stepEn,
  input  logic                   stepDown,
  input  logic [`DATA_WIDTH-1:0] writeData,
  output logic [`DATA_WIDTH-1:0] value,
  output logic [`DATA_WIDTH-1:0] regNext
);

  // load wins over step, wrap is natural 8-bit
  always_comb begin
    if (loadEn) begin
      regNext = writeData;
    end else if (stepEn) begin
      regNext = stepDown ? value - 1'b1 : value + 1'b1;
    end else begin
      regNext = value;
    end
  end

  always_ff @(posedge phi2 or negedge rstN) begin
    if (!rstN) begin
      value <= '0;
    end else begin
      value <= regNext;
    end
  end

endmodule

// File: source/writeBack.sv
// ----------------------------------------------------------
// write-back stage, register commands, flags and data out
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "datapathDefines.svh"

module writeBack (
  input  logic                   phi2,
  input  logic                   rstN,
  input  logic                   issueValid,
  input  datapathPkg::microWord_t issueWord,
  input  logic [`DATA_WIDTH-1:0] operandA,
  input  logic [`DATA_WIDTH-1:0] operandB,
  output logic [`NUM_REGS-1:0]   loadEn,
  output logic [`NUM_REGS-1:0]   stepEn,
  output logic                   stepDown,
  output logic [`DATA_WIDTH-1:0] writeData,
  output logic [`DATA_WIDTH-1:0] dataOut,
  output logic                   dataOutValid,
  output logic [3:0]             flagsNvzc
);
  import datapathPkg::*;

  logic [`DATA_WIDTH-1:0] aluResult;
  logic [`DATA_WIDTH-1:0] flagValue;
  logic                   aluCarry;
  logic                   aluOverflow;
  logic                   carryIn;
  logic                   isAlu;
  logic                   flagWrite;
  logic                   dorWrite;

  assign isAlu    = issueValid & issueWord.alu.kind;
  assign stepDown = issueWord.xfer.src[0];
  // C flag sits in bit 0
  assign carryIn  = issueWord.alu.useCarry & flagsNvzc[0];
  assign dorWrite = issueValid & ~issueWord.xfer.kind & ~issueWord.xfer.stepEn &
                    (issueWord.xfer.dst == `DST_DOR);

  aluCore alu (
    .opA        (operandA),
    .opB        (operandB),
    .op         (issueWord.alu.op),
    .carryIn    (carryIn),
    .result     (aluResult),
    .carryOut   (aluCarry),
    .overflowOut(aluOverflow)
  );

  always_comb begin
    loadEn    = '0;
    stepEn    = '0;
    writeData = isAlu ? aluResult : operandA;
    flagWrite = 1'b0;
    flagValue = writeData;
    if (issueValid && !issueWord.xfer.kind && issueWord.xfer.dst < `NUM_REGS) begin
      flagWrite = 1'b1;
      if (issueWord.xfer.stepEn) begin
        stepEn[issueWord.xfer.dst[1:0]] = 1'b1;
        // stepped value mirrored here only for N and Z
        flagValue = stepDown ? operandA - 1'b1 : operandA + 1'b1;
      end else begin
        loadEn[issueWord.xfer.dst[1:0]] = 1'b1;
      end
    end else if (isAlu) begin
      loadEn[issueWord.alu.dst] = 1'b1;
      flagWrite = 1'b1;
    end
  end

  // flags are {N, V, Z, C}
  always_ff @(posedge phi2 or negedge rstN) begin
    if (!rstN) begin
      flagsNvzc    <= '0;
      dataOut      <= '0;
      dataOutValid <= 1'b0;
    end else begin
      dataOutValid <= dorWrite;
      if (dorWrite) begin
        dataOut <= operandA;
      end
      if (flagWrite) begin
        flagsNvzc[3] <= flagValue[`DATA_WIDTH-1];
        flagsNvzc[1] <= (flagValue == '0);
      end
      if (isAlu && issueWord.alu.op == aluSum) begin
        flagsNvzc[2] <= aluOverflow;
        flagsNvzc[0] <= aluCarry;
      end else if (isAlu && issueWord.alu.op == aluShiftRight) begin
        flagsNvzc[0] <= aluCarry;
      end
    end
  end

endmodule

// File: tb.f
+incdir+source
source/datapathPkg.sv
source/regSlice.sv
source/aluCore.sv
source/microIssue.sv
source/writeBack.sv
source/datapathTop.sv
dv/datapathAssert.sv
dv/datapathTb.sv
